// File: test/user_io_golden.hex
// cmd count p0 p1 p2 p3 p4 p5 p6 p7 p8 p9 | exp {sw,bt} joy0 joy1 status ps2_count
// 10-byte ps2 frames all come out, the transmitter drains faster than spi fills a queue
01 01 f9 00 00 00 00 00 00 00 00 00 09 00 00 00 00
02 01 5a 00 00 00 00 00 00 00 00 00 09 5a 00 00 00
03 01 c3 00 00 00 00 00 00 00 00 00 09 5a c3 00 00
15 01 81 00 00 00 00 00 00 00 00 00 09 5a c3 81 00
07 02 ff ff 00 00 00 00 00 00 00 00 09 5a c3 81 00
05 03 1c 32 23 00 00 00 00 00 00 00 09 5a c3 81 03
04 03 08 10 f0 00 00 00 00 00 00 00 09 5a c3 81 03
05 01 5a 00 00 00 00 00 00 00 00 00 09 5a c3 81 01
04 02 09 ff 00 00 00 00 00 00 00 00 09 5a c3 81 02
02 02 11 22 00 00 00 00 00 00 00 00 09 22 c3 81 00
05 0a 01 02 03 04 05 06 07 08 09 0a 09 22 c3 81 0a
04 0a a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 09 22 c3 81 0a
01 01 02 00 00 00 00 00 00 00 00 00 02 22 c3 81 00
00 01 33 00 00 00 00 00 00 00 00 00 02 22 c3 81 00
15 02 7e 00 00 00 00 00 00 00 00 00 02 22 c3 00 00
03 01 00 00 00 00 00 00 00 00 00 00 02 22 00 00 00

// File: sources.f
+incdir+verilog
verilog/user_io_pkg.sv
verilog/spi_byte_rx.sv
verilog/cmd_decoder.sv
verilog/ps2_buf_arbiter.sv
verilog/ps2_tx.sv
verilog/user_io_top.sv
test/user_io_sva.sv
test/user_io_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = user_io_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/user_io_tb.sv
// ****************************************
// stimulus and expected values come from test/user_io_golden.hex
// run from the project root so the data file path resolves
// ****************************************
`default_nettype none

`include "user_io_config.svh"

module user_io_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// records and bytes per record in the data file
	localparam int NREC = 16;
	localparam int RLEN = 17;

	logic ps2_clk = 1'b0;
	logic SPI_SS_IO;
	logic spi_clk;
	logic spi_mosi;
	logic spi_ss;
	logic spi_miso;
	logic [1:0] buttons;
	logic [1:0] switches;
	user_io_pkg::byte_t joystick_0;
	user_io_pkg::byte_t joystick_1;
	user_io_pkg::byte_t status;
	logic ps2_kbd_clk;
	logic ps2_kbd_data;
	logic ps2_mouse_clk;
	logic ps2_mouse_data;

	user_io_pkg::byte_t golden [NREC*RLEN];
	// expected and decoded bytes per channel
	user_io_pkg::byte_t kbd_exp [$];
	user_io_pkg::byte_t kbd_got [$];
	user_io_pkg::byte_t mouse_exp [$];
	user_io_pkg::byte_t mouse_got [$];
	int checks = 0;
	int errors = 0;
	int cycle_limit = 0;
	logic [31:0] rand_state;

	user_io_top UUT (
		.ps2_clk(ps2_clk), .SPI_SS_IO(SPI_SS_IO), .spi_clk(spi_clk),
		.spi_mosi(spi_mosi), .spi_ss(spi_ss), .spi_miso(spi_miso),
		.buttons(buttons), .switches(switches), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .status(status),
		.ps2_kbd_clk(ps2_kbd_clk), .ps2_kbd_data(ps2_kbd_data),
		.ps2_mouse_clk(ps2_mouse_clk), .ps2_mouse_data(ps2_mouse_data)
	);

	// 20 ns period
	always #10 ps2_clk = ~ps2_clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] seed);
		return seed * 32'd1664525 + 32'd1013904223;
	endfunction

	// all stimulus changes on the falling edge
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge ps2_clk);
	endtask

	task automatic compare_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error: %s expected %h got %h", name, exp, got);
		end
	endtask

	// reset values, lines idle high
	task automatic check_idle();
		compare_byte("buttons", {6'b0, buttons}, 8'h00);
		compare_byte("switches", {6'b0, switches}, 8'h00);
		compare_byte("joystick_0", joystick_0, 8'h00);
		compare_byte("joystick_1", joystick_1, 8'h00);
		compare_byte("status", status, 8'h00);
		compare_byte("spi_miso", {7'b0, spi_miso}, 8'h00);
		compare_byte("ps2_kbd_clk", {7'b0, ps2_kbd_clk}, 8'h01);
		compare_byte("ps2_kbd_data", {7'b0, ps2_kbd_data}, 8'h01);
		compare_byte("ps2_mouse_clk", {7'b0, ps2_mouse_clk}, 8'h01);
		compare_byte("ps2_mouse_data", {7'b0, ps2_mouse_data}, 8'h01);
	endtask

	// start 0, odd parity over data and parity, stop 1
	task automatic check_frame(input string chan, input logic [10:0] bits);
		checks += 3;
		assert (bits[0] == 1'b0) else begin
			errors++;
			$display("%s frame has no low start bit", chan);
		end
		assert (^bits[9:1] == 1'b1) else begin
			errors++;
			$display("%s frame has even parity", chan);
		end
		assert (bits[10] == 1'b1) else begin
			errors++;
			$display("%s frame has no high stop bit", chan);
		end
	endtask

	// command byte then payload, 5 cycles low and 5 high per bit, msb first
	task automatic send_frame(input int rec);
		int base;
		int nbytes;
		user_io_pkg::byte_t b;
		user_io_pkg::byte_t miso_byte;
		base = rec * RLEN;
		nbytes = int'(golden[base+1]) + 1;
		spi_ss = 1'b0;
		for (int i = 0; i < nbytes; i++) begin
			b = (i == 0) ? golden[base] : golden[base+1+i];
			for (int k = 7; k >= 0; k--) begin
				spi_mosi = b[k];
				wait_cycles(5);
				// miso is settled by the end of the low phase
				if (i == 0)
					miso_byte[k] = spi_miso;
				spi_clk = 1'b1;
				wait_cycles(5);
				spi_clk = 1'b0;
			end
		end
		spi_mosi = 1'b0;
		wait_cycles(5);
		spi_ss = 1'b1;
		// every frame opens with core type a4
		compare_byte("spi_miso", miso_byte, 8'ha4);
	endtask

	// register columns 12..15 hold the state after the frame
	task automatic check_regs(input int rec);
		int base;
		base = rec * RLEN;
		compare_byte("buttons", {6'b0, buttons}, {6'b0, golden[base+12][1:0]});
		compare_byte("switches", {6'b0, switches}, {6'b0, golden[base+12][3:2]});
		compare_byte("joystick_0", joystick_0, golden[base+13]);
		compare_byte("joystick_1", joystick_1, golden[base+14]);
		compare_byte("status", status, golden[base+15]);
	endtask

	// first n payload bytes are expected on the channel of the command
	task automatic queue_expected(input int rec);
		int base;
		int n;
		base = rec * RLEN;
		n = int'(golden[base+16]);
		for (int j = 0; j < n; j++) begin
			if (golden[base] == `USER_IO_CMD_PS2_MOUSE)
				mouse_exp.push_back(golden[base+2+j]);
			else if (golden[base] == `USER_IO_CMD_PS2_KBD)
				kbd_exp.push_back(golden[base+2+j]);
		end
	endtask

	task automatic compare_channel(input bit mouse);
		int n_exp;
		int n_got;
		string name;
		name = mouse ? "ps2_mouse_data" : "ps2_kbd_data";
		n_exp = mouse ? mouse_exp.size() : kbd_exp.size();
		n_got = mouse ? mouse_got.size() : kbd_got.size();
		checks++;
		assert (n_got == n_exp) else begin
			errors++;
			$display("%s carried %0d bytes where %0d were expected", name, n_got, n_exp);
		end
		for (int i = 0; i < n_exp && i < n_got; i++) begin
			if (mouse)
				compare_byte($sformatf("%s byte %0d", name, i), mouse_got[i], mouse_exp[i]);
			else
				compare_byte($sformatf("%s byte %0d", name, i), kbd_got[i], kbd_exp[i]);
		end
	endtask

	// host side decoders, sampled on the falling line clock
	initial begin : kbd_monitor
		logic [10:0] bits;
		@(negedge SPI_SS_IO);
		forever begin
			for (int i = 0; i < 11; i++) begin
				@(negedge ps2_kbd_clk);
				bits[i] = ps2_kbd_data;
			end
			check_frame("keyboard", bits);
			kbd_got.push_back(bits[8:1]);
		end
	end

	initial begin : mouse_monitor
		logic [10:0] bits;
		@(negedge SPI_SS_IO);
		forever begin
			for (int i = 0; i < 11; i++) begin
				@(negedge ps2_mouse_clk);
				bits[i] = ps2_mouse_data;
			end
			check_frame("mouse", bits);
			mouse_got.push_back(bits[8:1]);
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		@(negedge SPI_SS_IO);
		while (cycles < cycle_limit) begin
			@(posedge ps2_clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the run did not finish", cycles);
		$display("tests failed");
		$finish;
	end

	initial begin : main
		int frame_bits;
		int ps2_frames;
		SPI_SS_IO = 1'b1;
		spi_clk = 1'b0;
		spi_mosi = 1'b0;
		spi_ss = 1'b1;
		frame_bits = 0;
		ps2_frames = 0;
		rand_state = 32'h5cf4;
		$readmemh("test/user_io_golden.hex", golden);
		// spi bits at 10 cycles, ps2 frames at 12, slack per frame, then 2x
		for (int r = 0; r < NREC; r++) begin
			frame_bits += (int'(golden[r*RLEN+1]) + 1) * 8;
			ps2_frames += int'(golden[r*RLEN+16]);
		end
		cycle_limit = 2 * (frame_bits * 10 + ps2_frames * 12 + NREC * 40);

		// reset held for 4 cycles, checked inside and after
		wait_cycles(2);
		check_idle();
		wait_cycles(2);
		SPI_SS_IO = 1'b0;
		wait_cycles(2);
		check_idle();

		for (int r = 0; r < NREC; r++) begin
			send_frame(r);
			wait_cycles(4);
			check_regs(r);
			queue_expected(r);
			// random idle gap of 2..17 cycles
			rand_state = lcg_next(rand_state);
			wait_cycles(2 + int'(rand_state[19:16]));
		end

		// let both queues drain, extra time catches surplus frames
		while (kbd_got.size() < kbd_exp.size() || mouse_got.size() < mouse_exp.size())
			wait_cycles(1);
		wait_cycles(40);
		compare_channel(1'b0);
		compare_channel(1'b1);

		$display("checks %0d, errors %0d, keyboard frames %0d, mouse frames %0d",
			checks, errors, kbd_got.size(), mouse_got.size());
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/user_io_sva.sv
// ****************************************
// bound into both ps2_tx instances
// ****************************************
`default_nettype none

module user_io_sva (
	input wire                          ps2_clk,
	input wire                          SPI_SS_IO,
	input wire user_io_pkg::ps2_state_e state,
	input wire                          rd_req,
	input wire                          line_data
);
	timeunit 1ns;
	timeprecision 1ps;

	// running xor over data bits and parity
	logic odd_acc;

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			odd_acc <= 1'b0;
		end else if (state == user_io_pkg::TX_START) begin
			odd_acc <= 1'b0;
		end else if (state >= user_io_pkg::TX_DATA0 && state <= user_io_pkg::TX_PARITY) begin
			odd_acc <= odd_acc ^ line_data;
		end
	end

	a_req_idle: assert property (@(posedge ps2_clk) disable iff (SPI_SS_IO)
		rd_req |-> state == user_io_pkg::TX_IDLE)
		else $error("rd_req high outside idle");

	// by stop the parity bit has been folded in
	a_parity_odd: assert property (@(posedge ps2_clk) disable iff (SPI_SS_IO)
		state == user_io_pkg::TX_STOP |-> odd_acc)
		else $error("data and parity not odd");

	a_stop_high: assert property (@(posedge ps2_clk) disable iff (SPI_SS_IO)
		state == user_io_pkg::TX_STOP |-> line_data)
		else $error("stop bit not high");

endmodule

bind ps2_tx user_io_sva u_sva (
	.ps2_clk(ps2_clk), .SPI_SS_IO(SPI_SS_IO), .state(state),
	.rd_req(rd_req), .line_data(ps2_line_data)
);

`default_nettype wire

// File: verilog/user_io_top.sv
// ****************************************
// everything on ps2_clk, spi_clk is sampled
// ****************************************
`default_nettype none

module user_io_top (
	input  wire                ps2_clk,
	input  wire                SPI_SS_IO,
	input  wire                spi_clk,
	input  wire                spi_mosi,
	input  wire                spi_ss,
	output logic               spi_miso,
	output logic [1:0]         buttons,
	output logic [1:0]         switches,
	output user_io_pkg::byte_t joystick_0,
	output user_io_pkg::byte_t joystick_1,
	output user_io_pkg::byte_t status,
	output logic               ps2_kbd_clk,
	output logic               ps2_kbd_data,
	output logic               ps2_mouse_clk,
	output logic               ps2_mouse_data
);

	user_io_pkg::spi_byte_t rx;
	user_io_pkg::inputs_t inputs;
	user_io_pkg::ps2_wr_t ps2_wr;
	user_io_pkg::ps2_rd_t kbd_rd;
	user_io_pkg::ps2_rd_t mouse_rd;
	logic kbd_req;
	logic mouse_req;
	logic kbd_avail;
	logic mouse_avail;

	spi_byte_rx u_spi_rx (
		.ps2_clk(ps2_clk), .SPI_SS_IO(SPI_SS_IO), .spi_clk(spi_clk),
		.spi_mosi(spi_mosi), .spi_ss(spi_ss), .spi_miso(spi_miso), .rx(rx)
	);

	cmd_decoder u_decoder (
		.ps2_clk(ps2_clk), .SPI_SS_IO(SPI_SS_IO), .rx(rx),
		.inputs(inputs), .ps2_wr(ps2_wr)
	);

	// one memory feeds both transmitters
	ps2_buf_arbiter u_arbiter (
		.ps2_clk(ps2_clk), .SPI_SS_IO(SPI_SS_IO), .ps2_wr(ps2_wr),
		.kbd_req(kbd_req), .mouse_req(mouse_req),
		.kbd_avail(kbd_avail), .mouse_avail(mouse_avail),
		.kbd_rd(kbd_rd), .mouse_rd(mouse_rd)
	);

	ps2_tx u_kbd_tx (
		.ps2_clk(ps2_clk), .SPI_SS_IO(SPI_SS_IO), .data_avail(kbd_avail),
		.rd_req(kbd_req), .rd(kbd_rd),
		.ps2_line_clk(ps2_kbd_clk), .ps2_line_data(ps2_kbd_data)
	);

	ps2_tx u_mouse_tx (
		.ps2_clk(ps2_clk), .SPI_SS_IO(SPI_SS_IO), .data_avail(mouse_avail),
		.rd_req(mouse_req), .rd(mouse_rd),
		.ps2_line_clk(ps2_mouse_clk), .ps2_line_data(ps2_mouse_data)
	);

	// register struct out to the core ports
	assign buttons    = inputs.buttons;
	assign switches   = inputs.switches;
	assign joystick_0 = inputs.joystick_0;
	assign joystick_1 = inputs.joystick_1;
	assign status     = inputs.status;

endmodule

`default_nettype wire

// File: verilog/ps2_tx.sv
// ****************************************
// device side only, no host-to-device path
// ****************************************
`default_nettype none

module ps2_tx (
	input  wire                     ps2_clk,
	input  wire                     SPI_SS_IO,
	input  wire                     data_avail,
	output logic                    rd_req,
	input  wire user_io_pkg::ps2_rd_t rd,
	output logic                    ps2_line_clk,
	output logic                    ps2_line_data
);

	user_io_pkg::ps2_state_e state;
	user_io_pkg::byte_t shreg;
	logic parity;

	// ask while idle, drop as soon as the byte shows up
	assign rd_req = (state == user_io_pkg::TX_IDLE) && data_avail && !rd.valid;

	// clock only runs during a frame
	assign ps2_line_clk = ps2_clk | (state == user_io_pkg::TX_IDLE);

	// line changes on the rising edge, host samples on the falling one
	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			state         <= user_io_pkg::TX_IDLE;
			ps2_line_data <= 1'b1;
		end else begin
			case (state)
				user_io_pkg::TX_IDLE: begin
					if (rd.valid) begin
						// start bit
						state         <= user_io_pkg::TX_START;
						ps2_line_data <= 1'b0;
					end
				end
				user_io_pkg::TX_DATA7: begin
					state         <= user_io_pkg::TX_PARITY;
					ps2_line_data <= parity;
				end
				user_io_pkg::TX_PARITY: begin
					// stop bit
					state         <= user_io_pkg::TX_STOP;
					ps2_line_data <= 1'b1;
				end
				user_io_pkg::TX_STOP: begin
					state <= user_io_pkg::TX_IDLE;
				end
				// start and data0..data6, next bit lsb first
				default: begin
					state         <= user_io_pkg::ps2_state_e'(state + 4'd1);
					ps2_line_data <= shreg[0];
				end
			endcase
		end
	end

	// byte and its odd parity latched at load
	always_ff @(posedge ps2_clk) begin
		if (state == user_io_pkg::TX_IDLE && rd.valid) begin
			shreg  <= rd.data;
			parity <= ~^rd.data;
		end else if (state != user_io_pkg::TX_IDLE) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

endmodule

`default_nettype wire

// File: verilog/ps2_buf_arbiter.sv
// ****************************************
// full queues drop writes, no overwrite
// read data follows the grant by one cycle
// ****************************************
`default_nettype none

`include "user_io_config.svh"

module ps2_buf_arbiter (
	input  wire                     ps2_clk,
	input  wire                     SPI_SS_IO,
	input  wire user_io_pkg::ps2_wr_t ps2_wr,
	input  wire                     kbd_req,
	input  wire                     mouse_req,
	output logic                    kbd_avail,
	output logic                    mouse_avail,
	output user_io_pkg::ps2_rd_t    kbd_rd,
	output user_io_pkg::ps2_rd_t    mouse_rd
);

	typedef logic [`USER_IO_PS2_AW-1:0] ptr_t;

	// lower half keyboard, upper half mouse
	user_io_pkg::byte_t mem [2*`USER_IO_PS2_DEPTH];

	// index 0 keyboard, index 1 mouse
	ptr_t wptr [2];
	ptr_t rptr [2];
	logic [1:0] full;
	logic [1:0] empty;
	logic [1:0] wr_sel;
	logic [1:0] wr_en;
	logic [1:0] req;
	logic [1:0] ok;
	logic [1:0] grant;
	logic [1:0] rd_valid;
	user_io_pkg::byte_t rd_data [2];
	user_io_pkg::ps2_chan_e prio;

	always_comb begin
		req    = {mouse_req, kbd_req};
		wr_sel = {ps2_wr.chan == user_io_pkg::PS2_MOUSE, ps2_wr.chan == user_io_pkg::PS2_KBD};
		for (int c = 0; c < 2; c++) begin
			// equal pointers mean empty unless the full bit says otherwise
			empty[c] = (wptr[c] == rptr[c]) && !full[c];
			wr_en[c] = ps2_wr.valid && wr_sel[c] && !full[c];
			// no second grant while the answer is still on its way
			ok[c]    = req[c] && !empty[c] && !rd_valid[c];
		end
		// round robin only matters when both ask at once
		grant[0] = ok[0] && (!ok[1] || prio == user_io_pkg::PS2_KBD);
		grant[1] = ok[1] && (!ok[0] || prio == user_io_pkg::PS2_MOUSE);
	end

	assign kbd_avail   = !empty[0];
	assign mouse_avail = !empty[1];

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			for (int c = 0; c < 2; c++) begin
				wptr[c] <= '0;
				rptr[c] <= '0;
			end
			full     <= '0;
			rd_valid <= '0;
			prio     <= user_io_pkg::PS2_KBD;
		end else begin
			for (int c = 0; c < 2; c++) begin
				if (wr_en[c])
					wptr[c] <= wptr[c] + 1'b1;
				if (grant[c])
					rptr[c] <= rptr[c] + 1'b1;
				// write catching up with the read pointer fills the queue
				if (wr_en[c] && !grant[c] && (ptr_t'(wptr[c] + 1'b1) == rptr[c]))
					full[c] <= 1'b1;
				else if (grant[c] && !wr_en[c])
					full[c] <= 1'b0;
			end
			rd_valid <= grant;
			// the channel just served goes to the back
			if (grant[0])
				prio <= user_io_pkg::PS2_MOUSE;
			else if (grant[1])
				prio <= user_io_pkg::PS2_KBD;
		end
	end

	// shared memory, one write port and a read per channel
	always_ff @(posedge ps2_clk) begin
		if (wr_en[0] || wr_en[1])
			mem[{ps2_wr.chan, wr_sel[1] ? wptr[1] : wptr[0]}] <= ps2_wr.data;
		if (grant[0])
			rd_data[0] <= mem[{1'b0, rptr[0]}];
		if (grant[1])
			rd_data[1] <= mem[{1'b1, rptr[1]}];
	end

	assign kbd_rd.data    = rd_data[0];
	assign kbd_rd.valid   = rd_valid[0];
	assign mouse_rd.data  = rd_data[1];
	assign mouse_rd.valid = rd_valid[1];

endmodule

`default_nettype wire

// File: verilog/cmd_decoder.sv
// ****************************************
// registers hold their values across frames
// unknown commands are ignored
// ****************************************
`default_nettype none

module cmd_decoder (
	input  wire                     ps2_clk,
	input  wire                     SPI_SS_IO,
	input  wire user_io_pkg::spi_byte_t rx,
	output user_io_pkg::inputs_t    inputs,
	output user_io_pkg::ps2_wr_t    ps2_wr
);

	// command of the current frame
	user_io_pkg::cmd_e cmd;

	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cmd    <= user_io_pkg::CMD_NONE;
			inputs <= '0;
			ps2_wr <= '0;
		end else begin
			// write strobe lasts one cycle
			ps2_wr.valid <= 1'b0;

			if (rx.valid) begin
				if (rx.idx == '0) begin
					// byte 0 selects what the rest of the frame means
					cmd <= user_io_pkg::cmd_e'(rx.data);
				end else begin
					case (cmd)
						user_io_pkg::CMD_BUT_SW: begin
							// low nibble only
							inputs.buttons  <= rx.data[1:0];
							inputs.switches <= rx.data[3:2];
						end

						user_io_pkg::CMD_JOY_0: begin
							inputs.joystick_0 <= rx.data;
						end

						user_io_pkg::CMD_JOY_1: begin
							inputs.joystick_1 <= rx.data;
						end

						// every payload byte goes into the mouse queue
						user_io_pkg::CMD_PS2_MOUSE: begin
							ps2_wr.chan  <= user_io_pkg::PS2_MOUSE;
							ps2_wr.data  <= rx.data;
							ps2_wr.valid <= 1'b1;
						end

						// same for the keyboard queue
						user_io_pkg::CMD_PS2_KBD: begin
							ps2_wr.chan  <= user_io_pkg::PS2_KBD;
							ps2_wr.data  <= rx.data;
							ps2_wr.valid <= 1'b1;
						end

						user_io_pkg::CMD_STATUS: begin
							inputs.status <= rx.data;
						end

						// anything else leaves all registers alone
						default: begin
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/spi_byte_rx.sv
// ****************************************
// spi_clk must stay high and low >= 4 ps2_clk cycles each
// ****************************************
`default_nettype none

`include "user_io_config.svh"

module spi_byte_rx (
	input  wire                     ps2_clk,
	input  wire                     SPI_SS_IO,
	input  wire                     spi_clk,
	input  wire                     spi_mosi,
	input  wire                     spi_ss,
	output logic                    spi_miso,
	output user_io_pkg::spi_byte_t  rx
);

	// synchronizer chains, oldest sample at the top bit
	logic [`USER_IO_SPI_SYNC-1:0] sclk_sync;
	logic [`USER_IO_SPI_SYNC-1:0] mosi_sync;
	logic [`USER_IO_SPI_SYNC-1:0] ss_sync;
	logic sclk_d;
	logic ss_d;
	logic sclk_s;
	logic mosi_s;
	logic ss_s;
	logic sclk_rise;
	logic sclk_fall;
	logic ss_fall;
	logic [2:0] bit_cnt;
	logic [6:0] sbuf;
	user_io_pkg::byte_idx_t idx;
	user_io_pkg::byte_t core_type;

	assign core_type = `USER_IO_CORE_TYPE;

	assign sclk_s = sclk_sync[`USER_IO_SPI_SYNC-1];
	assign mosi_s = mosi_sync[`USER_IO_SPI_SYNC-1];
	assign ss_s   = ss_sync[`USER_IO_SPI_SYNC-1];

	// edges seen against the previous synchronized sample
	assign sclk_rise = sclk_s & ~sclk_d;
	assign sclk_fall = ~sclk_s & sclk_d;
	assign ss_fall   = ~ss_s & ss_d;

	// select idles high, so its chain starts at ones
	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			ss_sync   <= '1;
			sclk_d    <= 1'b0;
			ss_d      <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[`USER_IO_SPI_SYNC-2:0], spi_clk};
			mosi_sync <= {mosi_sync[`USER_IO_SPI_SYNC-2:0], spi_mosi};
			ss_sync   <= {ss_sync[`USER_IO_SPI_SYNC-2:0], spi_ss};
			sclk_d    <= sclk_s;
			ss_d      <= ss_s;
		end
	end

	// bit and byte counters, cleared while the frame select is high
	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= 3'd0;
			idx     <= '0;
			rx      <= '0;
		end else begin
			rx.valid <= 1'b0;
			if (ss_s) begin
				bit_cnt <= 3'd0;
				idx     <= '0;
			end else if (sclk_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					// last bit comes straight from the synchronizer
					rx.data  <= {sbuf, mosi_s};
					rx.idx   <= idx;
					rx.valid <= 1'b1;
					// index sticks at the top value for long frames
					if (idx != `USER_IO_SPI_IDX_MAX)
						idx <= idx + 8'd1;
				end
			end
		end
	end

	// msb first
	always_ff @(posedge ps2_clk) begin
		if (!ss_s && sclk_rise)
			sbuf <= {sbuf[5:0], mosi_s};
	end

	// core type on miso during byte 0, bit 7 ready at frame start
	always_ff @(posedge ps2_clk or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			spi_miso <= 1'b0;
		end else if (ss_s) begin
			spi_miso <= 1'b0;
		end else if (ss_fall || sclk_fall) begin
			spi_miso <= (idx == '0) ? core_type[~bit_cnt] : 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/user_io_pkg.sv
// ****************************************
// shared types, command codes come from the config header
// ****************************************
`default_nettype none

`include "user_io_config.svh"

package user_io_pkg;

	// plain data byte and position inside a frame
	typedef logic [7:0] byte_t;
	typedef logic [7:0] byte_idx_t;

	// command byte, values outside the list are ignored by the decoder
	typedef enum logic [7:0] {
		CMD_NONE      = 8'h00,
		CMD_BUT_SW    = `USER_IO_CMD_BUT_SW,
		CMD_JOY_0     = `USER_IO_CMD_JOY_0,
		CMD_JOY_1     = `USER_IO_CMD_JOY_1,
		CMD_PS2_MOUSE = `USER_IO_CMD_PS2_MOUSE,
		CMD_PS2_KBD   = `USER_IO_CMD_PS2_KBD,
		CMD_STATUS    = `USER_IO_CMD_STATUS
	} cmd_e;

	typedef enum logic {
		PS2_KBD   = 1'b0,
		PS2_MOUSE = 1'b1
	} ps2_chan_e;

	// transmitter steps in frame order, the fsm counts through them
	typedef enum logic [3:0] {
		TX_IDLE, TX_START,
		TX_DATA0, TX_DATA1, TX_DATA2, TX_DATA3,
		TX_DATA4, TX_DATA5, TX_DATA6, TX_DATA7,
		TX_PARITY, TX_STOP
	} ps2_state_e;

	// one received spi byte, 17 bits
	typedef struct packed {
		byte_t     data;
		byte_idx_t idx;
		logic      valid;
	} spi_byte_t;

	// queue write, 10 bits
	typedef struct packed {
		ps2_chan_e chan;
		byte_t     data;
		logic      valid;
	} ps2_wr_t;

	// read answer to one transmitter, 9 bits
	typedef struct packed {
		byte_t data;
		logic  valid;
	} ps2_rd_t;

	// 28 bits of input registers
	typedef struct packed {
		logic [1:0] buttons;
		logic [1:0] switches;
		byte_t      joystick_0;
		byte_t      joystick_1;
		byte_t      status;
	} inputs_t;

endpackage

`default_nettype wire

// File: verilog/user_io_config.svh
// ****************************************
// core type, command codes and PS/2 queue sizes
// depth and address width must agree (depth = 2**aw)
// ****************************************
`ifndef USER_IO_CONFIG_SVH
`define USER_IO_CONFIG_SVH

// first byte returned on miso in every frame, 8 bit core
`define USER_IO_CORE_TYPE 8'ha4

// command bytes written by the io controller
`define USER_IO_CMD_BUT_SW    8'h01
`define USER_IO_CMD_JOY_0     8'h02
`define USER_IO_CMD_JOY_1     8'h03
`define USER_IO_CMD_PS2_MOUSE 8'h04
`define USER_IO_CMD_PS2_KBD   8'h05
`define USER_IO_CMD_STATUS    8'h15

// each ps2 queue, two of them share one memory
`define USER_IO_PS2_DEPTH 8
`define USER_IO_PS2_AW    3

// spi input sampling
`define USER_IO_SPI_SYNC    2
`define USER_IO_SPI_IDX_MAX 8'd255

`endif
